// File: source/imuldiv_pkg.sv
/*
  shared types and constants for the iterative multiply/divide unit
  operands are 32 bits; every result is a 64-bit word
*/
`default_nettype none

package imuldiv_pkg;

  // ---------------------------------------------------------------------
  // data widths
  // ---------------------------------------------------------------------

  // one operand, or a quotient or remainder half
  typedef logic [31:0] operand_t;

  // full product, or {remainder, quotient}
  typedef logic [63:0] result_t;

  // ---------------------------------------------------------------------
  // request function
  // ---------------------------------------------------------------------

  typedef enum logic [1:0] {
    FN_MUL  = 2'd0,  // signed multiply, 64-bit product
    FN_DIV  = 2'd1,  // signed divide
    FN_DIVU = 2'd2   // unsigned divide
  } muldiv_fn_t;

  // ---------------------------------------------------------------------
  // iteration control
  // ---------------------------------------------------------------------

  // one result bit per loop cycle
  localparam int ITERATIONS = 32;

  // wide enough for 0 .. ITERATIONS
  typedef logic [5:0] count_t;

  // divider controller states
  typedef enum logic [1:0] {
    DIV_IDLE = 2'd0,
    DIV_CALC = 2'd1,
    DIV_DONE = 2'd2
  } div_state_t;

  // multiplier states
  typedef enum logic [1:0] {
    MUL_IDLE = 2'd0,
    MUL_CALC = 2'd1,
    MUL_DONE = 2'd2
  } mul_state_t;

endpackage

`default_nettype wire

// File: source/imuldiv_div_dpath.sv
/*
  restoring divider datapath; no handshake here, the controller owns it
  divide by zero gives an unspecified result
*/
`default_nettype none

module imuldiv_div_dpath (
  input  logic                  clk,
  input  logic                  reset,
  input  imuldiv_pkg::operand_t req_a,
  input  imuldiv_pkg::operand_t req_b,
  input  logic                  signed_op,
  input  logic                  a_en,
  input  logic                  b_en,
  input  logic                  fn_en,
  input  logic                  sign_en,
  input  logic                  a_mux_sel,
  output imuldiv_pkg::result_t  result
);
  import imuldiv_pkg::*;

  // remainder in [64:32], quotient grows in from bit 0
  logic [64:0] a_reg;
  // divisor magnitude, aligned to the remainder half
  logic [64:0] b_reg;
  logic        fn_reg;
  logic        sign_a;
  logic        sign_b;

  operand_t    mag_a;
  operand_t    mag_b;
  logic [64:0] a_shift;
  logic [64:0] sub_out;
  logic [64:0] step_out;
  logic [64:0] a_mux_out;
  operand_t    quotient;
  operand_t    remainder;
  logic        neg_quot;
  logic        neg_rem;

  // ---------------------------------------------------------------------
  // operand magnitudes
  // ---------------------------------------------------------------------

  // unsigned divide takes the operands as they are
  assign mag_a = (signed_op && req_a[31]) ? (~req_a + 32'd1) : req_a;
  assign mag_b = (signed_op && req_b[31]) ? (~req_b + 32'd1) : req_b;

  // ---------------------------------------------------------------------
  // shift-subtract step
  // ---------------------------------------------------------------------

  assign a_shift = a_reg << 1;
  assign sub_out = a_shift - b_reg;

  // non-negative difference: keep it and shift in a quotient 1
  // the low bit of sub_out is always 0 since b_reg[31:0] is zero
  assign step_out = sub_out[64] ? a_shift : {sub_out[64:1], 1'b1};

  // load the dividend at the start, the step result afterwards
  assign a_mux_out = a_mux_sel ? step_out : {33'd0, mag_a};

  always_ff @(posedge clk) begin
    if (a_en) begin
      a_reg <= a_mux_out;
    end
    if (b_en) begin
      b_reg <= {1'b0, mag_b, 32'd0};
    end
  end

  // function and sign bits for the final fix
  always_ff @(posedge clk) begin
    if (reset) begin
      fn_reg <= 1'b0;
      sign_a <= 1'b0;
      sign_b <= 1'b0;
    end else begin
      if (fn_en) begin
        fn_reg <= signed_op;
      end
      if (sign_en) begin
        sign_a <= req_a[31];
        sign_b <= req_b[31];
      end
    end
  end

  // ---------------------------------------------------------------------
  // sign fix
  // ---------------------------------------------------------------------

  // quotient sign is the xor of the operand signs
  // remainder follows the dividend (C-style truncation)
  assign neg_quot = fn_reg && (sign_a ^ sign_b);
  assign neg_rem  = fn_reg && sign_a;

  assign quotient  = neg_quot ? (~a_reg[31:0] + 32'd1) : a_reg[31:0];
  assign remainder = neg_rem ? (~a_reg[63:32] + 32'd1) : a_reg[63:32];

  assign result = {remainder, quotient};

endmodule

`default_nettype wire

// File: source/imuldiv_div_ctrl.sv
/*
  divider FSM: one operation at a time, always the full 32 iterations
  resp_val is held until resp_rdy is seen on an edge
*/
`default_nettype none

module imuldiv_div_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  input  logic resp_rdy,
  output logic req_rdy,
  output logic resp_val,
  output logic a_en,
  output logic b_en,
  output logic fn_en,
  output logic sign_en,
  output logic a_mux_sel
);
  import imuldiv_pkg::*;

  localparam count_t LAST = count_t'(ITERATIONS - 1);

  div_state_t state;
  count_t     count;
  logic       req_go;
  logic       resp_go;

  assign req_go  = req_val && req_rdy;
  assign resp_go = resp_val && resp_rdy;

  // ---------------------------------------------------------------------
  // state and iteration counter
  // ---------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= DIV_IDLE;
      count <= '0;
    end else begin
      case (state)
        DIV_IDLE: begin
          if (req_go) begin
            state <= DIV_CALC;
            count <= '0;
          end
        end
        DIV_CALC: begin
          // last step lands on the 32nd edge after accept
          if (count == LAST) begin
            state <= DIV_DONE;
          end else begin
            count <= count + count_t'(1);
          end
        end
        DIV_DONE: begin
          if (resp_go) begin
            state <= DIV_IDLE;
          end
        end
        default: begin
          state <= DIV_IDLE;
        end
      endcase
    end
  end

  // ---------------------------------------------------------------------
  // enables, mux select, handshake
  // ---------------------------------------------------------------------

  always_comb begin
    req_rdy   = 1'b0;
    resp_val  = 1'b0;
    a_en      = 1'b0;
    b_en      = 1'b0;
    fn_en     = 1'b0;
    sign_en   = 1'b0;
    a_mux_sel = 1'b0;
    case (state)
      DIV_IDLE: begin
        req_rdy = 1'b1;
        // load operands, function and signs on the transfer edge
        a_en    = req_go;
        b_en    = req_go;
        fn_en   = req_go;
        sign_en = req_go;
      end
      DIV_CALC: begin
        a_en      = 1'b1;
        a_mux_sel = 1'b1;
      end
      DIV_DONE: begin
        resp_val = 1'b1;
      end
      default: begin
        req_rdy = 1'b0;
      end
    endcase
  end

  // a pending result stays valid and keeps new requests out until taken
  assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val && !req_rdy);

  // counter stays inside the iteration range
  assert property (@(posedge clk) disable iff (reset) count <= LAST);

endmodule

`default_nettype wire

// File: source/imuldiv_mul_iterative.sv
/*
  shift-add signed multiplier, 32 cycles per product, one at a time
  magnitudes are multiplied and the product sign is applied at the output
*/
`default_nettype none

module imuldiv_mul_iterative (
  input  logic                  clk,
  input  logic                  reset,
  input  imuldiv_pkg::operand_t req_a,
  input  imuldiv_pkg::operand_t req_b,
  input  logic                  req_val,
  output logic                  req_rdy,
  output imuldiv_pkg::result_t  resp_result,
  input  logic                  resp_rdy,
  output logic                  resp_val
);
  import imuldiv_pkg::*;

  localparam count_t LAST = count_t'(ITERATIONS - 1);

  mul_state_t state;
  count_t     count;
  logic       req_go;
  logic       resp_go;

  // multiplicand shifts left, multiplier shifts right
  result_t    mcand;
  operand_t   mplier;
  result_t    acc;
  logic       neg;
  operand_t   mag_a;
  operand_t   mag_b;

  assign req_go  = req_val && req_rdy;
  assign resp_go = resp_val && resp_rdy;

  assign mag_a = req_a[31] ? (~req_a + 32'd1) : req_a;
  assign mag_b = req_b[31] ? (~req_b + 32'd1) : req_b;

  // ---------------------------------------------------------------------
  // FSM
  // ---------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= MUL_IDLE;
      count <= '0;
    end else begin
      case (state)
        MUL_IDLE: begin
          if (req_go) begin
            state <= MUL_CALC;
            count <= '0;
          end
        end
        MUL_CALC: begin
          if (count == LAST) begin
            state <= MUL_DONE;
          end else begin
            count <= count + count_t'(1);
          end
        end
        MUL_DONE: begin
          if (resp_go) begin
            state <= MUL_IDLE;
          end
        end
        default: begin
          state <= MUL_IDLE;
        end
      endcase
    end
  end

  assign req_rdy  = (state == MUL_IDLE);
  assign resp_val = (state == MUL_DONE);

  // ---------------------------------------------------------------------
  // shift-add datapath
  // ---------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (req_go) begin
      mcand  <= {32'd0, mag_a};
      mplier <= mag_b;
      acc    <= '0;
      neg    <= req_a[31] ^ req_b[31];
    end else if (state == MUL_CALC) begin
      // add the aligned multiplicand for each set multiplier bit
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  // 2^62 is the largest magnitude, so the negate cannot overflow
  assign resp_result = neg ? (~acc + 64'd1) : acc;

  // no new request is offered while a product waits to be taken
  assert property (@(posedge clk) disable iff (reset) resp_val |-> !req_val);

endmodule

`default_nettype wire

// File: source/imuldiv_muldiv.sv
/*
  multiply/divide top: one request in flight across both units
  responses come back in request order; no added latency
*/
`default_nettype none

module imuldiv_muldiv (
  input  logic                    clk,
  input  logic                    reset,
  input  imuldiv_pkg::muldiv_fn_t req_fn,
  input  imuldiv_pkg::operand_t   req_a,
  input  imuldiv_pkg::operand_t   req_b,
  input  logic                    req_val,
  output logic                    req_rdy,
  output imuldiv_pkg::result_t    resp_result,
  output logic                    resp_val,
  input  logic                    resp_rdy
);
  import imuldiv_pkg::*;

  logic    is_div;
  logic    div_signed;
  logic    div_req_val;
  logic    div_req_rdy;
  logic    div_resp_val;
  result_t div_resp_result;
  logic    mul_req_val;
  logic    mul_req_rdy;
  logic    mul_resp_val;
  result_t mul_resp_result;

  // divider controller to datapath
  logic    a_en;
  logic    b_en;
  logic    fn_en;
  logic    sign_en;
  logic    a_mux_sel;

  // ---------------------------------------------------------------------
  // request steering
  // ---------------------------------------------------------------------

  assign is_div     = (req_fn == FN_DIV) || (req_fn == FN_DIVU);
  assign div_signed = (req_fn == FN_DIV);

  // both units idle before anything is accepted
  assign req_rdy = div_req_rdy && mul_req_rdy;

  // unit valids also wait on req_rdy, so no unit takes a request the
  // requester does not see as transferred
  assign div_req_val = req_val && req_rdy && is_div;
  assign mul_req_val = req_val && req_rdy && (req_fn == FN_MUL);

  // ---------------------------------------------------------------------
  // units
  // ---------------------------------------------------------------------

  imuldiv_div_dpath div_dpath (
    .clk       (clk),
    .reset     (reset),
    .req_a     (req_a),
    .req_b     (req_b),
    .signed_op (div_signed),
    .a_en      (a_en),
    .b_en      (b_en),
    .fn_en     (fn_en),
    .sign_en   (sign_en),
    .a_mux_sel (a_mux_sel),
    .result    (div_resp_result)
  );

  imuldiv_div_ctrl div_ctrl (
    .clk       (clk),
    .reset     (reset),
    .req_val   (div_req_val),
    .resp_rdy  (resp_rdy),
    .req_rdy   (div_req_rdy),
    .resp_val  (div_resp_val),
    .a_en      (a_en),
    .b_en      (b_en),
    .fn_en     (fn_en),
    .sign_en   (sign_en),
    .a_mux_sel (a_mux_sel)
  );

  imuldiv_mul_iterative mul (
    .clk         (clk),
    .reset       (reset),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (mul_req_val),
    .req_rdy     (mul_req_rdy),
    .resp_result (mul_resp_result),
    .resp_rdy    (resp_rdy),
    .resp_val    (mul_resp_val)
  );

  // ---------------------------------------------------------------------
  // response merge
  // ---------------------------------------------------------------------

  assign resp_val    = div_resp_val || mul_resp_val;
  assign resp_result = div_resp_val ? div_resp_result : mul_resp_result;

  // at most one unit busy, so never two responses at once
  assert property (@(posedge clk) disable iff (reset) !(div_resp_val && mul_resp_val));

endmodule

`default_nettype wire

// File: tests/imuldiv_muldiv_tb.sv
/*
  self-checking testbench for the multiply/divide top; run from the project root
  vectors and offline results come from tests/imuldiv_testdata.txt; no divide by zero
*/
`default_nettype none

module imuldiv_muldiv_tb;
  import imuldiv_pkg::*;

  localparam int NUM_VECTORS  = 21;
  // fn, a, b, expected, stall
  localparam int WORDS        = 5;
  localparam int MAX_GAP      = 3;
  localparam int RESET_CYCLES = 16;
  localparam int LATENCY      = 32;
  localparam int DRIVE_DELAY  = 2;
  localparam int MARGIN       = 100;

  logic       clk;
  logic       reset;
  muldiv_fn_t req_fn;
  operand_t   req_a;
  operand_t   req_b;
  logic       req_val;
  logic       req_rdy;
  result_t    resp_result;
  logic       resp_val;
  logic       resp_rdy;

  logic [63:0] vec_mem [0:NUM_VECTORS*WORDS-1];
  // edge numbers of accepted requests, oldest first
  int          accept_q[$];
  int          cycle = 0;
  int          limit = 100000;
  int          errors = 0;
  int          checked = 0;
  int          max_stall = 0;
  int          seed;
  logic        data_ok;

  imuldiv_muldiv DUT (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  // ---------------------------------------------------------------------
  // clock, edge counter, run limit
  // ---------------------------------------------------------------------

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  always @(posedge clk) begin
    if (cycle >= limit) begin
      $display("timeout: run stopped at cycle %0d before all responses arrived", cycle);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // ---------------------------------------------------------------------
  // helpers
  // ---------------------------------------------------------------------

  // inputs change and outputs are sampled just after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  function automatic string fn_name(input logic [1:0] f);
    case (f)
      2'd0: return "mul";
      2'd1: return "div";
      2'd2: return "divu";
      default: return "bad";
    endcase
  endfunction

  task automatic report_mismatch(input string name, input string what,
                                 input logic [63:0] expected, input logic [63:0] actual);
    $display("Error: %s %s expected %h actual %h", name, what, expected, actual);
    errors++;
  endtask

  // ---------------------------------------------------------------------
  // request side
  // ---------------------------------------------------------------------

  task automatic drive_requests();
    int gap;
    int base;
    for (int i = 0; i < NUM_VECTORS; i++) begin
      base = i * WORDS;
      // random idle gap, 0 gives back-to-back requests
      gap = $urandom % (MAX_GAP + 1);
      repeat (gap) next_cycle();
      req_fn  = muldiv_fn_t'(vec_mem[base][1:0]);
      req_a   = vec_mem[base + 1][31:0];
      req_b   = vec_mem[base + 2][31:0];
      req_val = 1'b1;
      // hold the request stable until both units are idle
      while (req_rdy !== 1'b1) next_cycle();
      // transfer happens on the coming edge
      accept_q.push_back(cycle + 1);
      next_cycle();
      req_val = 1'b0;
    end
  endtask

  // ---------------------------------------------------------------------
  // response side, in request order
  // ---------------------------------------------------------------------

  task automatic collect_responses();
    int      base;
    int      stall;
    int      accept_edge;
    result_t expected;
    result_t held;
    string   name;
    for (int j = 0; j < NUM_VECTORS; j++) begin
      base     = j * WORDS;
      expected = vec_mem[base + 3];
      stall    = int'(vec_mem[base + 4]);
      name     = $sformatf("vector %0d %s", j, fn_name(vec_mem[base][1:0]));
      while (resp_val !== 1'b1) next_cycle();
      if (accept_q.size() == 0) begin
        $display("response for %s arrived with no accepted request outstanding", name);
        errors++;
        accept_edge = cycle - LATENCY;
      end else begin
        accept_edge = accept_q.pop_front();
      end
      // valid rises on the 32nd edge after the accept edge
      if (cycle - accept_edge != LATENCY) begin
        report_mismatch(name, "latency", LATENCY, cycle - accept_edge);
      end
      if (resp_result !== expected) begin
        report_mismatch(name, "result", expected, resp_result);
      end
      if (req_rdy !== 1'b0) begin
        report_mismatch(name, "req_rdy with response pending", 0, req_rdy);
      end
      held = resp_result;
      // back-pressure: result held, no new request taken
      repeat (stall) begin
        next_cycle();
        if (resp_val !== 1'b1) begin
          report_mismatch(name, "resp_val under stall", 1, resp_val);
        end
        if (resp_result !== held) begin
          report_mismatch(name, "result under stall", held, resp_result);
        end
        if (req_rdy !== 1'b0) begin
          report_mismatch(name, "req_rdy under stall", 0, req_rdy);
        end
      end
      resp_rdy = 1'b1;
      next_cycle();
      resp_rdy = 1'b0;
      checked++;
      // unit back in idle right after the response transfer
      if (resp_val !== 1'b0) begin
        report_mismatch(name, "resp_val after transfer", 0, resp_val);
      end
      if (req_rdy !== 1'b1) begin
        report_mismatch(name, "req_rdy after transfer", 1, req_rdy);
      end
    end
  endtask

  // ---------------------------------------------------------------------
  // main sequence
  // ---------------------------------------------------------------------

  initial begin
    seed       = 61;
    void'($urandom(seed));
    reset      = 1'b1;
    req_fn     = FN_MUL;
    req_a      = '0;
    req_b      = '0;
    req_val    = 1'b0;
    resp_rdy   = 1'b0;
    data_ok    = 1'b1;

    $readmemh("tests/imuldiv_testdata.txt", vec_mem);
    for (int k = 0; k < NUM_VECTORS; k++) begin
      for (int w = 0; w < WORDS; w++) begin
        if ($isunknown(vec_mem[k * WORDS + w])) begin
          data_ok = 1'b0;
        end
      end
      if (!$isunknown(vec_mem[k * WORDS + 4]) && int'(vec_mem[k * WORDS + 4]) > max_stall) begin
        max_stall = int'(vec_mem[k * WORDS + 4]);
      end
    end
    limit = RESET_CYCLES + NUM_VECTORS * (LATENCY + 1 + max_stall + MAX_GAP) + MARGIN;

    repeat (RESET_CYCLES) next_cycle();
    reset = 1'b0;
    if (req_rdy !== 1'b1) begin
      report_mismatch("reset", "req_rdy", 1, req_rdy);
    end
    if (resp_val !== 1'b0) begin
      report_mismatch("reset", "resp_val", 0, resp_val);
    end

    if (data_ok) begin
      fork
        drive_requests();
        collect_responses();
      join
      // nothing may follow the last response
      repeat (4) begin
        next_cycle();
        if (resp_val !== 1'b0) begin
          $display("extra response seen after the last vector");
          errors++;
        end
      end
    end else begin
      $display("test data file is missing or has too few vectors");
      errors++;
    end

    $display("%0d of %0d vectors checked, %0d errors", checked, NUM_VECTORS, errors);
    if (errors == 0 && checked == NUM_VECTORS) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/imuldiv_testdata.txt
// fn a b expected stall, all hex; fn 0 = mul, 1 = div, 2 = divu
// expected is the 64-bit product, or {remainder, quotient} with C-style truncation
0 00000007 00000006 000000000000002a 0
1 00000014 00000006 0000000200000003 2
0 fffffffd 00000005 fffffffffffffff1 0
2 ffffffff 00000010 0000000f0fffffff 1
0 fffffffc fffffff8 0000000000000020 3
1 ffffffec 00000006 fffffffefffffffd 0
0 80000000 80000000 4000000000000000 5
2 80000000 00000003 000000022aaaaaaa 0
0 80000000 00000001 ffffffff80000000 1
1 00000014 fffffffa 00000002fffffffd 0
0 7fffffff 7fffffff 3fffffff00000001 2
1 ffffffec fffffffa fffffffe00000003 0
0 12345678 00010000 0000123456780000 0
2 fffffffe ffffffff fffffffe00000000 4
0 80000000 ffffffff 0000000080000000 0
1 80000000 ffffffff 0000000080000000 3
2 87654321 00001000 0000032100087654 0
1 00000007 00000007 0000000000000001 1
2 00000064 00000007 000000020000000e 0
1 00000003 0000000a 0000000300000000 2
1 fffffff9 00000002 fffffffffffffffd 0

// File: project.f
source/imuldiv_pkg.sv
source/imuldiv_div_dpath.sv
source/imuldiv_div_ctrl.sv
source/imuldiv_mul_iterative.sv
source/imuldiv_muldiv.sv
tests/imuldiv_muldiv_tb.sv

// File: Bender.yml
package:
  name: imuldiv

sources:
  - files:
      - source/imuldiv_pkg.sv
      - source/imuldiv_div_dpath.sv
      - source/imuldiv_div_ctrl.sv
      - source/imuldiv_mul_iterative.sv
      - source/imuldiv_muldiv.sv
  - target: test
    files:
      - tests/imuldiv_muldiv_tb.sv
